// File: Makefile
TOP = exec_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: design/exec_alu.sv
/*
 * Operand selection and ALU, result = reg2 op reg1/imm5.
 * Result and flags are held from exec_en until the next exec_en.
 * Shift amount is the low five bits of the first operand.
 */
`default_nettype none

module exec_alu (
   input  wire                            CLK,
   input  wire                            exec_en,
   input  exec_pkg::alu_op_t              alu_op,
   input  wire                            use_imm,
   input  wire  [exec_pkg::IMM_W-1:0]     imm5,
   input  wire                            is_setf,
   input  wire                            cond_met,
   input  wire  [exec_pkg::XLEN-1:0]      rs_data,
   input  wire  [exec_pkg::XLEN-1:0]      rd_data,
   output logic [exec_pkg::XLEN-1:0]      result,
   output logic [exec_pkg::FLAG_W-1:0]    result_flags
);

   logic [exec_pkg::XLEN-1:0]   op1, op2, imm_ext, alu_out;
   logic [exec_pkg::FLAG_W-1:0] alu_fl;
   logic [4:0]                  shamt;
   logic                        sext;
   logic                        s1, s2, so;
   logic                        cy, ov;

   ////////////////////////////////////////
   // Operands

   // MOV, ADD and CMP take a signed imm5, shifts an unsigned one
   assign sext = (alu_op == exec_pkg::ALU_MOV) || (alu_op == exec_pkg::ALU_ADD) ||
                 (alu_op == exec_pkg::ALU_SUB);
   assign imm_ext = sext ? {{(exec_pkg::XLEN-exec_pkg::IMM_W){imm5[exec_pkg::IMM_W-1]}}, imm5}
                         : {{(exec_pkg::XLEN-exec_pkg::IMM_W){1'b0}}, imm5};

   always_comb begin
      if (is_setf) begin
         op1 = {{(exec_pkg::XLEN-1){1'b0}}, cond_met};
      end else if (use_imm) begin
         op1 = imm_ext;
      end else begin
         op1 = rs_data;
      end
   end

   assign op2   = rd_data;
   assign shamt = op1[4:0];
   assign s1    = op1[exec_pkg::XLEN-1];
   assign s2    = op2[exec_pkg::XLEN-1];
   assign so    = alu_out[exec_pkg::XLEN-1];

   ////////////////////////////////////////
   // ALU

   always_comb begin
      cy      = 1'b0;
      ov      = 1'b0;
      alu_out = op1;
      case (alu_op)
         exec_pkg::ALU_MOV: alu_out = op1;
         exec_pkg::ALU_ADD: begin
            {cy, alu_out} = {1'b0, op2} + {1'b0, op1};
            ov = (s1 == s2) && (s2 != alu_out[exec_pkg::XLEN-1]);
         end
         exec_pkg::ALU_SUB: begin
            {cy, alu_out} = {1'b0, op2} - {1'b0, op1};   // Borrow in CY
            ov = (s1 != s2) && (s2 != alu_out[exec_pkg::XLEN-1]);
         end
         // CY is the last bit shifted out, zero for a zero shift
         exec_pkg::ALU_SHL: {cy, alu_out} = {1'b0, op2} << shamt;
         exec_pkg::ALU_SHR: {alu_out, cy} = {op2, 1'b0} >> shamt;
         exec_pkg::ALU_SAR: {alu_out, cy} = $signed({op2, 1'b0}) >>> shamt;
         exec_pkg::ALU_OR:  alu_out = op2 | op1;
         exec_pkg::ALU_AND: alu_out = op2 & op1;
         exec_pkg::ALU_XOR: alu_out = op2 ^ op1;
         exec_pkg::ALU_NOT: alu_out = ~op1;
         default: ;
      endcase
   end

   always_comb begin
      alu_fl                    = '0;
      alu_fl[exec_pkg::FLAG_Z]  = (alu_out == '0);
      alu_fl[exec_pkg::FLAG_S]  = so;
      alu_fl[exec_pkg::FLAG_OV] = ov;
      alu_fl[exec_pkg::FLAG_CY] = cy;
   end

   always_ff @(posedge CLK) begin
      if (exec_en) begin
         result       <= alu_out;
         result_flags <= alu_fl;
      end
   end

endmodule

`default_nettype wire

// File: design/exec_ctrl.sv
/*
 * Sequencer: IDLE, EXECUTE, COMMIT, then IDLE or HALTED.
 * Strobes outside IDLE are dropped. Only reset leaves HALTED.
 */
`default_nettype none

module exec_ctrl (
   input  wire   CLK,
   input  wire   arst_n,
   input  wire   ins_valid,
   input  wire   is_halt,
   output logic  load_ins,
   output logic  exec_en,
   output logic  commit,
   output logic  busy,
   output logic  halted
);

   exec_pkg::ctrl_state_t state, state_nxt;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state <= exec_pkg::ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         exec_pkg::ST_IDLE: begin
            if (ins_valid) begin
               state_nxt = exec_pkg::ST_EXECUTE;
            end
         end
         exec_pkg::ST_EXECUTE: state_nxt = exec_pkg::ST_COMMIT;
         exec_pkg::ST_COMMIT:  state_nxt = is_halt ? exec_pkg::ST_HALTED : exec_pkg::ST_IDLE;
         exec_pkg::ST_HALTED:  state_nxt = exec_pkg::ST_HALTED;
      endcase
   end

   assign load_ins = ins_valid && (state == exec_pkg::ST_IDLE);
   assign exec_en  = (state == exec_pkg::ST_EXECUTE);
   assign commit   = (state == exec_pkg::ST_COMMIT);   // Also the done pulse
   assign busy     = (state != exec_pkg::ST_IDLE);
   assign halted   = (state == exec_pkg::ST_HALTED);

   // Single-cycle commit, sticky halt
   a_commit_pulse: assert property (@(posedge CLK) disable iff (!arst_n)
      commit |=> (state != exec_pkg::ST_COMMIT))
      else $error("commit held for more than one cycle");

   a_halt_sticky: assert property (@(posedge CLK) disable iff (!arst_n)
      (state == exec_pkg::ST_HALTED) |=> (state == exec_pkg::ST_HALTED))
      else $error("left halted state without reset");

endmodule

`default_nettype wire

// File: design/exec_decode.sv
/*
 * Instruction register and decoder for the 16-bit register formats.
 * Undefined opcodes decode to a no-op: no write, no flag update.
 */
`default_nettype none

module exec_decode (
   input  wire                            CLK,
   input  wire                            arst_n,
   input  wire                            load_ins,
   input  wire  [exec_pkg::INS_W-1:0]     ins,
   output logic [exec_pkg::REG_AW-1:0]    rs_addr,
   output logic [exec_pkg::REG_AW-1:0]    rd_addr,
   output logic [exec_pkg::IMM_W-1:0]     imm5,
   output exec_pkg::alu_op_t              alu_op,
   output logic                           use_imm,
   output logic                           is_setf,
   output logic [exec_pkg::COND_W-1:0]    cond,
   output exec_pkg::flag_upd_t            flag_upd,
   output logic                           reg_write,
   output logic                           is_halt
);

   logic [exec_pkg::INS_W-1:0] ir;
   exec_pkg::opcode_t          opc;
   logic                       imm_form;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         ir <= '0;   // Decodes as MOV r0, r0
      end else if (load_ins) begin
         ir <= ins;
      end
   end

   ////////////////////////////////////////
   // Fields

   assign opc      = exec_pkg::opcode_t'(ir[exec_pkg::OPC_LSB +: exec_pkg::OPC_W]);
   assign rs_addr  = ir[exec_pkg::RS_LSB +: exec_pkg::REG_AW];
   assign rd_addr  = ir[exec_pkg::RD_LSB +: exec_pkg::REG_AW];
   assign imm5     = ir[exec_pkg::RS_LSB +: exec_pkg::IMM_W];
   assign cond     = ir[exec_pkg::RS_LSB +: exec_pkg::COND_W];
   assign imm_form = ir[exec_pkg::OPC_LSB + 4];   // Format II bit

   ////////////////////////////////////////
   // Control

   always_comb begin
      alu_op    = exec_pkg::ALU_MOV;
      use_imm   = 1'b0;
      is_setf   = 1'b0;
      flag_upd  = exec_pkg::UPD_NONE;
      reg_write = 1'b0;
      is_halt   = 1'b0;

      case (opc)
         exec_pkg::OP_MOV_R, exec_pkg::OP_MOV_I: begin
            use_imm   = imm_form;
            reg_write = 1'b1;
         end
         exec_pkg::OP_ADD_R, exec_pkg::OP_ADD_I, exec_pkg::OP_SUB_R: begin
            alu_op    = exec_pkg::alu_op_t'(opc[3:0]);
            use_imm   = imm_form;
            flag_upd  = exec_pkg::UPD_ARITH;
            reg_write = 1'b1;
         end
         exec_pkg::OP_CMP_R, exec_pkg::OP_CMP_I: begin
            alu_op   = exec_pkg::ALU_SUB;   // Flags only
            use_imm  = imm_form;
            flag_upd = exec_pkg::UPD_ARITH;
         end
         exec_pkg::OP_SHL_R, exec_pkg::OP_SHR_R, exec_pkg::OP_SAR_R,
         exec_pkg::OP_SHL_I, exec_pkg::OP_SHR_I, exec_pkg::OP_SAR_I,
         exec_pkg::OP_OR_R, exec_pkg::OP_AND_R, exec_pkg::OP_XOR_R,
         exec_pkg::OP_NOT_R: begin
            alu_op    = exec_pkg::alu_op_t'(opc[3:0]);
            use_imm   = imm_form;
            flag_upd  = exec_pkg::UPD_LOGIC;
            reg_write = 1'b1;
         end
         exec_pkg::OP_SETF: begin
            is_setf   = 1'b1;   // Moves the condition result
            reg_write = 1'b1;
         end
         exec_pkg::OP_HALT: is_halt = 1'b1;
         default: ;
      endcase

      // r0 is never a real destination
      if (rd_addr == '0) begin
         reg_write = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: design/exec_flags.sv
/*
 * Program status flags with masked update at commit.
 * cond_met reflects the flags before the commit of the current instruction.
 */
`default_nettype none

module exec_flags (
   input  wire                            CLK,
   input  wire                            arst_n,
   input  wire                            commit,
   input  exec_pkg::flag_upd_t            flag_upd,
   input  wire  [exec_pkg::FLAG_W-1:0]    result_flags,
   input  wire  [exec_pkg::COND_W-1:0]    cond,
   output logic [exec_pkg::FLAG_W-1:0]    flags,
   output logic                           cond_met
);

   logic z, s, ov, cy;
   logic hit;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         flags <= '0;
      end else if (commit) begin
         case (flag_upd)
            exec_pkg::UPD_ARITH: flags <= result_flags;
            exec_pkg::UPD_LOGIC: begin
               flags[exec_pkg::FLAG_Z]  <= result_flags[exec_pkg::FLAG_Z];
               flags[exec_pkg::FLAG_S]  <= result_flags[exec_pkg::FLAG_S];
               flags[exec_pkg::FLAG_OV] <= 1'b0;   // CY untouched
            end
            default: ;
         endcase
      end
   end

   assign z  = flags[exec_pkg::FLAG_Z];
   assign s  = flags[exec_pkg::FLAG_S];
   assign ov = flags[exec_pkg::FLAG_OV];
   assign cy = flags[exec_pkg::FLAG_CY];

   ////////////////////////////////////////
   // Condition test

   always_comb begin
      case (cond[2:0])
         3'd0:    hit = ov;              // V
         3'd1:    hit = cy;              // C, unsigned lower
         3'd2:    hit = z;               // Z, equal
         3'd3:    hit = cy | z;          // NH
         3'd4:    hit = s;               // S, negative
         3'd5:    hit = 1'b1;            // T
         3'd6:    hit = s ^ ov;          // LT
         default: hit = (s ^ ov) | z;    // LTE
      endcase
      cond_met = hit ^ cond[3];   // Upper half inverts
   end

endmodule

`default_nettype wire

// File: design/exec_pkg.sv
/*
 * Shared widths, instruction fields and encodings of the execute unit.
 * Opcode and ALU codes keep the 16-bit register format of the source ISA.
 * Flag vector order is Z, S, OV, CY from bit 0 upward.
 */
`default_nettype none

package exec_pkg;

   localparam int XLEN   = 32;   // Data and register width
   localparam int REG_AW = 5;
   localparam int INS_W  = 16;
   localparam int FLAG_W = 4;

   // Instruction fields
   localparam int OPC_LSB = 10;
   localparam int OPC_W   = 6;
   localparam int RD_LSB  = 5;   // reg2, also the destination
   localparam int RS_LSB  = 0;   // reg1 or imm5
   localparam int IMM_W   = 5;
   localparam int COND_W  = 4;

   // Flag positions
   localparam int FLAG_Z  = 0;
   localparam int FLAG_S  = 1;
   localparam int FLAG_OV = 2;
   localparam int FLAG_CY = 3;

   ////////////////////////////////////////
   // Encodings

   typedef enum logic [OPC_W-1:0] {
      OP_MOV_R = 6'b000000,
      OP_ADD_R = 6'b000001,
      OP_SUB_R = 6'b000010,
      OP_CMP_R = 6'b000011,
      OP_SHL_R = 6'b000100,
      OP_SHR_R = 6'b000101,
      OP_SAR_R = 6'b000111,
      OP_OR_R  = 6'b001100,
      OP_AND_R = 6'b001101,
      OP_XOR_R = 6'b001110,
      OP_NOT_R = 6'b001111,
      OP_MOV_I = 6'b010000,
      OP_ADD_I = 6'b010001,
      OP_SETF  = 6'b010010,
      OP_CMP_I = 6'b010011,
      OP_SHL_I = 6'b010100,
      OP_SHR_I = 6'b010101,
      OP_SAR_I = 6'b010111,
      OP_HALT  = 6'b011010
   } opcode_t;

   // Same as the low four opcode bits of the ALU formats
   typedef enum logic [3:0] {
      ALU_MOV = 4'b0000,
      ALU_ADD = 4'b0001,
      ALU_SUB = 4'b0010,
      ALU_SHL = 4'b0100,
      ALU_SHR = 4'b0101,
      ALU_SAR = 4'b0111,
      ALU_OR  = 4'b1100,
      ALU_AND = 4'b1101,
      ALU_XOR = 4'b1110,
      ALU_NOT = 4'b1111
   } alu_op_t;

   typedef enum logic [1:0] {
      UPD_NONE  = 2'd0,
      UPD_ARITH = 2'd1,   // Z, S, OV, CY
      UPD_LOGIC = 2'd2    // Z, S, OV cleared, CY kept
   } flag_upd_t;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_EXECUTE = 2'd1,
      ST_COMMIT  = 2'd2,
      ST_HALTED  = 2'd3
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/exec_regfile.sv
/*
 * 32 x 32 register file, two combinational reads, one write port.
 * No reset, contents are undefined until written. r0 always reads zero.
 */
`default_nettype none

module exec_regfile (
   input  wire                           CLK,
   input  wire  [exec_pkg::REG_AW-1:0]   rs_addr,
   input  wire  [exec_pkg::REG_AW-1:0]   rd_addr,
   output logic [exec_pkg::XLEN-1:0]     rs_data,
   output logic [exec_pkg::XLEN-1:0]     rd_data,
   input  wire                           wr_en,
   input  wire  [exec_pkg::REG_AW-1:0]   wr_addr,
   input  wire  [exec_pkg::XLEN-1:0]     wr_data
);

   logic [exec_pkg::XLEN-1:0] regs [0:(1 << exec_pkg::REG_AW)-1];

   // Read ports, r0 forced to zero
   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

   always_ff @(posedge CLK) begin
      if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // Decoder must have filtered r0 destinations
   a_no_r0_write: assert property (@(posedge CLK) !(wr_en && (wr_addr == '0)))
      else $error("register file write to r0");

endmodule

`default_nettype wire

// File: design/exec_unit.sv
/*
 * Execute unit top. One instruction in flight, three cycles per instruction.
 * wr_* report each register write in the done cycle.
 */
`default_nettype none

module exec_unit (
   input  wire                           CLK,
   input  wire                           arst_n,
   input  wire                           ins_valid,
   input  wire  [exec_pkg::INS_W-1:0]    ins,
   output wire                           busy,
   output wire                           done,
   output wire                           halted,
   output wire                           wr_en,
   output wire  [exec_pkg::REG_AW-1:0]   wr_addr,
   output wire  [exec_pkg::XLEN-1:0]     wr_data,
   output wire  [exec_pkg::FLAG_W-1:0]   flags
);

   wire                          load_ins, exec_en, commit;
   wire                          is_halt, use_imm, is_setf, reg_write, cond_met;
   wire [exec_pkg::REG_AW-1:0]   rs_addr, rd_addr;
   wire [exec_pkg::IMM_W-1:0]    imm5;
   wire [exec_pkg::COND_W-1:0]   cond;
   wire [exec_pkg::XLEN-1:0]     rs_data, rd_data, result;
   wire [exec_pkg::FLAG_W-1:0]   result_flags;
   exec_pkg::alu_op_t            alu_op;
   exec_pkg::flag_upd_t          flag_upd;

   assign done    = commit;
   assign wr_en   = commit & reg_write;
   assign wr_addr = rd_addr;
   assign wr_data = result;

   exec_ctrl u_ctrl (
      .CLK(CLK), .arst_n(arst_n), .ins_valid(ins_valid), .is_halt(is_halt),
      .load_ins(load_ins), .exec_en(exec_en), .commit(commit),
      .busy(busy), .halted(halted)
   );

   exec_decode u_decode (
      .CLK(CLK), .arst_n(arst_n), .load_ins(load_ins), .ins(ins),
      .rs_addr(rs_addr), .rd_addr(rd_addr), .imm5(imm5), .alu_op(alu_op),
      .use_imm(use_imm), .is_setf(is_setf), .cond(cond), .flag_upd(flag_upd),
      .reg_write(reg_write), .is_halt(is_halt)
   );

   exec_regfile u_regfile (
      .CLK(CLK), .rs_addr(rs_addr), .rd_addr(rd_addr),
      .rs_data(rs_data), .rd_data(rd_data),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
   );

   exec_alu u_alu (
      .CLK(CLK), .exec_en(exec_en), .alu_op(alu_op), .use_imm(use_imm),
      .imm5(imm5), .is_setf(is_setf), .cond_met(cond_met),
      .rs_data(rs_data), .rd_data(rd_data),
      .result(result), .result_flags(result_flags)
   );

   exec_flags u_flags (
      .CLK(CLK), .arst_n(arst_n), .commit(commit), .flag_upd(flag_upd),
      .result_flags(result_flags), .cond(cond),
      .flags(flags), .cond_met(cond_met)
   );

endmodule

`default_nettype wire

// File: verification/exec_tb.sv
/*
 * Testbench for exec_unit. A reference model of the register file and flags
 * predicts each write and flag update, concurrent assertions compare them.
 * Register contents are set up by MOV immediates before any random operation.
 */
`default_nettype none

module exec_tb;
   timeunit 1ns;
   timeprecision 1ps;

   logic                          CLK = 1'b0;
   logic                          arst_n;
   logic                          ins_valid;
   logic [exec_pkg::INS_W-1:0]    ins;
   wire                           busy, done, halted, wr_en;
   wire  [exec_pkg::REG_AW-1:0]   wr_addr;
   wire  [exec_pkg::XLEN-1:0]     wr_data;
   wire  [exec_pkg::FLAG_W-1:0]   flags;

   integer                        seed;
   logic [exec_pkg::XLEN-1:0]     model_regs [32];
   logic [exec_pkg::FLAG_W-1:0]   model_flags;
   logic [exec_pkg::FLAG_W-1:0]   pend_flags;
   logic [exec_pkg::REG_AW-1:0]   pend_wr_addr;
   logic [exec_pkg::XLEN-1:0]     pend_wr_data;
   logic                          pend_wr_en, pend_halt, strobe_ok;
   int                            exp_accepts;
   logic [exec_pkg::FLAG_W-1:0]   cur_flags = '0;   // Committed model state
   logic                          cur_halt = 1'b0;
   int                            done_cnt = 0;

   exec_unit DUT (
      .CLK(CLK), .arst_n(arst_n), .ins_valid(ins_valid), .ins(ins),
      .busy(busy), .done(done), .halted(halted), .wr_en(wr_en),
      .wr_addr(wr_addr), .wr_data(wr_data), .flags(flags)
   );

   always #5 CLK = ~CLK;

   always @(posedge CLK) begin
      if (done) begin
         done_cnt  <= done_cnt + 1;
         cur_flags <= pend_flags;
         cur_halt  <= pend_halt;
      end
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   ////////////////////////////////////////
   // Checks

   a_after_reset: assert property (@(posedge CLK)
      $rose(arst_n) |-> (!busy && !done && !halted && !wr_en && flags == '0))
      else stop_run($sformatf("CHECK FAILED at %0t ns: outputs not idle after reset", $time));
   a_accept_timing: assert property (@(posedge CLK) disable iff (!arst_n)
      (ins_valid && !busy) |=> (busy && !done) ##1 (busy && done) ##1 !done)
      else stop_run($sformatf("CHECK FAILED at %0t ns: busy/done sequence wrong", $time));
   a_accept_expected: assert property (@(posedge CLK) disable iff (!arst_n)
      (ins_valid && !busy) |-> strobe_ok)
      else stop_run($sformatf("CHECK FAILED at %0t ns: strobe taken while busy", $time));
   a_done_count: assert property (@(posedge CLK) disable iff (!arst_n)
      done |-> (done_cnt < exp_accepts))
      else stop_run($sformatf("CHECK FAILED at %0t ns: done without accepted strobe", $time));
   a_wr_en: assert property (@(posedge CLK) disable iff (!arst_n)
      wr_en == (done && pend_wr_en))
      else stop_run($sformatf("CHECK FAILED at %0t ns: wr_en is %b", $time, $sampled(wr_en)));
   a_wr_data: assert property (@(posedge CLK) disable iff (!arst_n)
      wr_en |-> (wr_addr == pend_wr_addr && wr_data == pend_wr_data))
      else stop_run($sformatf("CHECK FAILED at %0t ns: r%0d <= %h, expected r%0d <= %h",
         $time, $sampled(wr_addr), $sampled(wr_data), pend_wr_addr, pend_wr_data));
   a_flags: assert property (@(posedge CLK) disable iff (!arst_n) flags == cur_flags)
      else stop_run($sformatf("CHECK FAILED at %0t ns: flags %b, expected %b",
         $time, $sampled(flags), $sampled(cur_flags)));
   a_halted: assert property (@(posedge CLK) disable iff (!arst_n)
      (halted == cur_halt) && (!halted || (busy && !done)))
      else stop_run($sformatf("CHECK FAILED at %0t ns: halted/busy/done wrong", $time));

   ////////////////////////////////////////
   // Reference model

   function automatic logic [15:0] encode(input logic [5:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs);
      return {opc, rd, rs};   // opcode 15..10, reg2 9..5, reg1 or imm5 4..0
   endfunction

   function automatic logic [31:0] sext5(input logic [4:0] v);
      return {{27{v[4]}}, v};
   endfunction

   function automatic logic cond_true(input logic [3:0] f, input logic [3:0] cc);
      logic z, s, v, c, t;
      z = f[exec_pkg::FLAG_Z];
      s = f[exec_pkg::FLAG_S];
      v = f[exec_pkg::FLAG_OV];
      c = f[exec_pkg::FLAG_CY];
      case (cc[2:0])
         3'd0:    t = v;
         3'd1:    t = c;
         3'd2:    t = z;
         3'd3:    t = c | z;
         3'd4:    t = s;
         3'd5:    t = 1'b1;
         3'd6:    t = s ^ v;
         default: t = (s ^ v) | z;
      endcase
      return cc[3] ? !t : t;   // Codes 8..15 are the inverses
   endfunction

   task automatic apply_model(input logic [15:0] w);
      logic [5:0]  opc;
      logic [4:0]  rd, rs, amt;
      logic [31:0] a, b, r;
      logic [32:0] sum;
      logic        c, v, wr;
      int          upd;        // 0 none, 1 arithmetic, 2 logic
      opc = w[15:10];
      rd  = w[9:5];
      rs  = w[4:0];
      a   = model_regs[rs];
      b   = model_regs[rd];
      amt = w[14] ? rs : a[4:0];
      r   = '0;
      c   = 1'b0;
      v   = 1'b0;
      wr  = 1'b1;
      upd = 0;
      case (opc)
         exec_pkg::OP_MOV_R: r = a;
         exec_pkg::OP_MOV_I: r = sext5(rs);
         exec_pkg::OP_ADD_R, exec_pkg::OP_ADD_I: begin
            if (w[14]) a = sext5(rs);
            sum = {1'b0, b} + {1'b0, a};
            r   = sum[31:0];
            c   = sum[32];
            v   = (a[31] == b[31]) && (r[31] != b[31]);
            upd = 1;
         end
         exec_pkg::OP_SUB_R, exec_pkg::OP_CMP_R, exec_pkg::OP_CMP_I: begin
            if (w[14]) a = sext5(rs);
            r   = b - a;
            c   = (b < a);   // Borrow
            v   = (a[31] != b[31]) && (r[31] != b[31]);
            wr  = (opc == exec_pkg::OP_SUB_R);
            upd = 1;
         end
         exec_pkg::OP_SHL_R, exec_pkg::OP_SHL_I: r = b << amt;
         exec_pkg::OP_SHR_R, exec_pkg::OP_SHR_I: r = b >> amt;
         exec_pkg::OP_SAR_R, exec_pkg::OP_SAR_I: r = $signed(b) >>> amt;
         exec_pkg::OP_OR_R:  r = b | a;
         exec_pkg::OP_AND_R: r = b & a;
         exec_pkg::OP_XOR_R: r = b ^ a;
         exec_pkg::OP_NOT_R: r = ~a;
         exec_pkg::OP_SETF:  r = {31'b0, cond_true(model_flags, rs[3:0])};
         default: wr = 1'b0;   // HALT and undefined opcodes
      endcase
      if (opc inside {exec_pkg::OP_SHL_R, exec_pkg::OP_SHR_R, exec_pkg::OP_SAR_R,
                      exec_pkg::OP_SHL_I, exec_pkg::OP_SHR_I, exec_pkg::OP_SAR_I,
                      exec_pkg::OP_OR_R, exec_pkg::OP_AND_R, exec_pkg::OP_XOR_R,
                      exec_pkg::OP_NOT_R}) begin
         upd = 2;
      end
      pend_flags = model_flags;
      if (upd != 0) begin
         pend_flags[exec_pkg::FLAG_Z]  = (r == '0);
         pend_flags[exec_pkg::FLAG_S]  = r[31];
         pend_flags[exec_pkg::FLAG_OV] = (upd == 1) && v;
         if (upd == 1) begin
            pend_flags[exec_pkg::FLAG_CY] = c;   // Logic group keeps CY
         end
      end
      pend_wr_en   = wr && (rd != '0);
      pend_wr_addr = rd;
      pend_wr_data = r;
      pend_halt    = (opc == exec_pkg::OP_HALT);
      model_flags  = pend_flags;
      if (pend_wr_en) begin
         model_regs[rd] = r;
      end
   endtask

   ////////////////////////////////////////
   // Stimulus

   function automatic logic [15:0] random_ins();
      logic [15:0] w;
      w     = 16'($random(seed));
      w[15] = 1'b0;   // Defined opcodes all lie below 32
      if (w[15:10] == exec_pkg::OP_HALT) begin
         w[15:10] = exec_pkg::OP_ADD_R;
      end
      return w;
   endfunction

   // Waits for idle, sends one instruction, then waits for its done
   task automatic issue(input logic [15:0] w, input bit noisy);
      int n;
      n = 0;
      @(negedge CLK);
      while (busy && n < 50) begin
         @(negedge CLK);
         n++;
      end
      if (busy) stop_run("timeout: DUT stayed busy, no instruction could be sent");
      apply_model(w);
      ins         = w;
      ins_valid   = 1'b1;
      strobe_ok   = 1'b1;
      exp_accepts = exp_accepts + 1;
      n = 0;
      @(negedge CLK);
      strobe_ok = 1'b0;
      while (!done && n < 50) begin
         ins_valid = noisy;   // Extra strobe lands while busy
         ins       = 16'($random(seed));
         @(negedge CLK);
         n++;
      end
      ins_valid = 1'b0;
      if (!done) stop_run("timeout: no done pulse after an accepted instruction");
   endtask

   initial begin
      seed          = 16;
      arst_n        = 1'b0;
      ins_valid     = 1'b0;
      ins           = '0;
      strobe_ok     = 1'b0;
      pend_wr_en    = 1'b0;
      pend_halt     = 1'b0;
      pend_wr_addr  = '0;
      pend_wr_data  = '0;
      pend_flags    = '0;
      model_flags   = '0;
      model_regs[0] = '0;
      exp_accepts   = 0;
      repeat (8) @(negedge CLK);
      arst_n = 1'b1;
      repeat (2) @(negedge CLK);

      for (int r = 1; r < 32; r++) begin
         issue(encode(exec_pkg::OP_MOV_I, 5'(r), 5'($random(seed))), 1'b0);
      end

      // Carry, borrow and overflow corners
      issue(encode(exec_pkg::OP_MOV_I, 5'd1, 5'h1f), 1'b0);
      issue(encode(exec_pkg::OP_MOV_I, 5'd2, 5'd1), 1'b0);
      issue(encode(exec_pkg::OP_ADD_R, 5'd1, 5'd2), 1'b0);
      issue(encode(exec_pkg::OP_OR_R, 5'd3, 5'd2), 1'b0);
      issue(encode(exec_pkg::OP_SUB_R, 5'd1, 5'd2), 1'b0);
      issue(encode(exec_pkg::OP_MOV_I, 5'd4, 5'h1f), 1'b0);
      issue(encode(exec_pkg::OP_SHR_I, 5'd4, 5'd1), 1'b0);
      issue(encode(exec_pkg::OP_ADD_I, 5'd4, 5'd1), 1'b0);
      issue(encode(exec_pkg::OP_SHL_I, 5'd4, 5'd31), 1'b0);

      // CMP, r0 as destination and as source
      issue(encode(exec_pkg::OP_CMP_R, 5'd5, 5'd6), 1'b0);
      issue(encode(exec_pkg::OP_ADD_I, 5'd0, 5'd7), 1'b0);
      issue(encode(exec_pkg::OP_MOV_R, 5'd8, 5'd0), 1'b0);

      for (int i = 0; i < 300; i++) begin
         issue(random_ins(), (i % 4) == 0);
      end

      for (int c = 0; c < 16; c++) begin
         issue(encode(c[0] ? exec_pkg::OP_ADD_R : exec_pkg::OP_CMP_R,
                      5'($random(seed)), 5'($random(seed))), 1'b0);
         issue(encode(exec_pkg::OP_SETF, 5'(c + 1), 5'(c)), 1'b0);
      end

      issue(encode(exec_pkg::OP_HALT, 5'd0, 5'd0), 1'b0);
      repeat (6) begin
         @(negedge CLK);
         ins_valid = 1'b1;
         ins       = random_ins();
         @(negedge CLK);
         ins_valid = 1'b0;
      end
      repeat (4) @(negedge CLK);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
design/exec_pkg.sv
design/exec_regfile.sv
design/exec_decode.sv
design/exec_alu.sv
design/exec_flags.sv
design/exec_ctrl.sv
design/exec_unit.sv
verification/exec_tb.sv
